// File: bf16_vec_add.f
+incdir+.
bf16_vec_pkg.sv
bf16_add_pipe.sv
operand_bank.sv
result_bank.sv
seq_counter.sv
vec_add_ctrl.sv
bf16_vec_add_top.sv
tb_bf16_vec_add.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_bf16_vec_add
FILELIST  = bf16_vec_add.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) tb_bf16_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_bf16_model.svh
`ifndef TB_BF16_MODEL_SVH
`define TB_BF16_MODEL_SVH

// shift that brings the top set bit in 7..1 up to bit 7, 7 when none
function automatic logic [2:0] model_lead_zeros(input logic [8:0] m);
	logic [2:0] n;
	logic       found;
	n = 3'd7;
	found = 1'b0;
	for (int i = 7; i >= 1; i--) begin
		if (m[i] && !found) begin
			n = 3'(7 - i);
			found = 1'b1;
		end
	end
	return n;
endfunction

// truncating bf16 add, hidden one always present, no inf or nan
function automatic bf16_vec_pkg::bf16_t model_add(input bf16_vec_pkg::bf16_t a,
		input bf16_vec_pkg::bf16_t b);
	logic [8:0]          ma, mb, m;
	logic [7:0]          e;
	logic                s;
	logic [2:0]          lz;
	bf16_vec_pkg::bf16_t r;
	ma = {2'b01, a.fields.mantissa};
	mb = {2'b01, b.fields.mantissa};
	// a keeps its mantissa only when its exponent is strictly larger
	if (a.fields.exponent > b.fields.exponent) begin
		e = a.fields.exponent;
		mb = mb >> (a.fields.exponent - b.fields.exponent);
	end else begin
		e = b.fields.exponent;
		ma = ma >> (b.fields.exponent - a.fields.exponent);
	end
	if (a.fields.sign == b.fields.sign) begin
		m = ma + mb;	// no renormalize on this path
		s = a.fields.sign;
	end else begin
		m = (ma > mb) ? ma - mb : mb - ma;
		s = (ma > mb) ? a.fields.sign : b.fields.sign;	// tie goes to b
		lz = model_lead_zeros(m);
		m = m << lz;
		e = e - 8'(lz);	// wraps freely
	end
	r = '0;
	r.fields.sign = s;
	if (e == 8'd0) begin
		r.fields.mantissa = {1'b0, m[6:1]};
	end else if (m[8]) begin
		r.fields.exponent = e + 8'd1;	// carry out of the add
		r.fields.mantissa = m[7:1];
	end else begin
		r.fields.exponent = e;
		r.fields.mantissa = m[6:0];
	end
	return r;
endfunction

`endif

// File: tb_bf16_vec_add.sv
`timescale 1ns/1ps

module tb_bf16_vec_add;

	// all tests need roughly 600 cycles, limit keeps a wide margin
	localparam int CYCLE_LIMIT = 2000;

	logic                                clk;
	logic                                reset;
	logic                                wr_en, wr_sel, start, busy, done;
	logic [bf16_vec_pkg::ADDR_W-1:0]     wr_addr, rd_addr;
	logic [bf16_vec_pkg::LEN_W-1:0]      len;
	bf16_vec_pkg::bf16_t                 wr_data, rd_data;

	bf16_vec_pkg::bf16_t vec_a [bf16_vec_pkg::VEC_DEPTH];
	bf16_vec_pkg::bf16_t vec_b [bf16_vec_pkg::VEC_DEPTH];
	bf16_vec_pkg::bf16_t res_model [bf16_vec_pkg::VEC_DEPTH];	// expected result bank
	bf16_vec_pkg::bf16_t last_read [bf16_vec_pkg::VEC_DEPTH];

	integer                    seed = 32'h0abd_127b;
	int                        word_errors = 0;
	int                        flag_errors = 0;
	int                        cycle_count = 0;
	bf16_vec_pkg::ctrl_state_t stuck_state;

	`include "tb_bf16_model.svh"

	bf16_vec_add_top uut (
		.clk(clk), .reset(reset),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr), .wr_data(wr_data),
		.start(start), .len(len),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.busy(busy), .done(done)
	);

	always #2 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			stuck_state = uut.u_ctrl.state;
			$display("timeout after %0d cycles, done never came, controller in %s",
				CYCLE_LIMIT, stuck_state.name());
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic check_word(input string name, input bf16_vec_pkg::bf16_t expected,
			input bf16_vec_pkg::bf16_t actual);
		if (actual.raw !== expected.raw) begin
			word_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected.raw, actual.raw);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic load_vectors(input int n);
		for (int i = 0; i < n; i++) begin
			for (int s = 0; s < 2; s++) begin
				@(posedge clk);
				wr_en   <= 1'b1;
				wr_sel  <= s[0];	// a first, then b
				wr_addr <= 4'(i);
				wr_data <= s[0] ? vec_b[i] : vec_a[i];
			end
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic start_run(input int n);
		@(posedge clk);
		start <= 1'b1;
		len   <= 5'(n);
		@(posedge clk);
		start <= 1'b0;	// dut samples the pulse here
	endtask

	// busy must hold until done, done lasts one cycle with busy low
	task automatic wait_done(input string name, input logic busy_expected);
		@(negedge clk);
		while (!done) begin
			check_flag({name, " busy during run"}, busy_expected, busy);
			@(negedge clk);
		end
		check_flag({name, " busy at done"}, 1'b0, busy);
		@(negedge clk);
		check_flag({name, " done width"}, 1'b0, done);
		check_flag({name, " busy after done"}, 1'b0, busy);
	endtask

	task automatic run_vector(input string name, input int n);
		start_run(n);
		for (int i = 0; i < n; i++)
			res_model[i] = model_add(vec_a[i], vec_b[i]);
		wait_done(name, n != 0);
	endtask

	task automatic read_result(input logic [3:0] addr, output bf16_vec_pkg::bf16_t word);
		@(posedge clk);
		rd_addr <= addr;
		@(posedge clk);	// registered read
		@(negedge clk);
		word = rd_data;
	endtask

	task automatic check_all(input string name);
		for (int i = 0; i < bf16_vec_pkg::VEC_DEPTH; i++) begin
			read_result(4'(i), last_read[i]);
			check_word($sformatf("%s[%0d]", name, i), res_model[i], last_read[i]);
		end
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++) begin
			vec_a[i].raw = 16'($random(seed));
			vec_b[i].raw = 16'($random(seed));
		end
	endtask

	task automatic test_same_sign;
		vec_a[0].raw = 16'h3f80;
		vec_b[0].raw = 16'h3f80;
		load_vectors(1);
		run_vector("same_sign", 1);
		check_all("same_sign");
		check_word("same_sign literal", 16'h4000, last_read[0]);	// 1 + 1 = 2
	endtask

	task automatic test_cancellation;
		vec_a[0].raw = 16'h3fc0;	// 1.5
		vec_b[0].raw = 16'hbfa0;	// -1.25
		vec_a[1].raw = 16'h3f80;
		vec_b[1].raw = 16'hbf40;
		vec_a[2].raw = 16'h4000;
		vec_b[2].raw = 16'hbffe;
		vec_a[3].raw = 16'hc120;
		vec_b[3].raw = 16'h411c;
		vec_a[4].raw = 16'h3f81;
		vec_b[4].raw = 16'hbf80;
		vec_a[5].raw = 16'h4280;
		vec_b[5].raw = 16'hc280;	// exact cancel
		load_vectors(6);
		run_vector("cancel", 6);
		check_all("cancel");
		check_word("cancel literal", 16'h3e80, last_read[0]);	// 0.25
	endtask

	task automatic test_exponent_gap;
		logic [31:0] r;
		for (int d = 1; d <= 9; d++) begin
			r = $random(seed);
			vec_a[d-1].fields.sign     = r[0];
			vec_a[d-1].fields.exponent = 8'(100 + d);
			vec_a[d-1].fields.mantissa = r[7:1];
			vec_b[d-1].fields.sign     = r[16] ? ~r[0] : r[0];	// mix add and sub
			vec_b[d-1].fields.exponent = 8'd100;
			vec_b[d-1].fields.mantissa = r[14:8];
		end
		load_vectors(9);
		run_vector("exp_gap", 9);
		check_all("exp_gap");
		for (int i = 0; i < 9; i++)
			check_flag($sformatf("exp_gap sign[%0d]", i), vec_a[i].fields.sign,
				last_read[i].fields.sign);
	endtask

	task automatic test_random_vector;
		fill_random(bf16_vec_pkg::VEC_DEPTH);
		load_vectors(bf16_vec_pkg::VEC_DEPTH);
		run_vector("random", bf16_vec_pkg::VEC_DEPTH);
		check_all("random");
	endtask

	task automatic test_zero_length;
		fill_random(bf16_vec_pkg::VEC_DEPTH);	// new operands make a stray write-back visible
		load_vectors(bf16_vec_pkg::VEC_DEPTH);
		run_vector("len_zero", 0);	// model stays untouched
		check_all("len_zero");
	endtask

	// host writes and a second start during a run must be dropped
	task automatic test_busy_lockout;
		start_run(bf16_vec_pkg::VEC_DEPTH);
		for (int k = 0; k < 5; k++) begin
			@(posedge clk);
			wr_en   <= 1'b1;
			wr_sel  <= k[0];
			wr_addr <= 4'(k);
			wr_data <= 16'(16'hdead ^ k);
			start   <= (k == 2);
			len     <= 5'd2;
		end
		@(posedge clk);
		wr_en <= 1'b0;
		start <= 1'b0;
		for (int i = 0; i < bf16_vec_pkg::VEC_DEPTH; i++)
			res_model[i] = model_add(vec_a[i], vec_b[i]);
		wait_done("lockout", 1'b1);
		check_all("lockout");
		run_vector("lockout rerun", bf16_vec_pkg::VEC_DEPTH);	// operands unchanged
		check_all("lockout rerun");
	endtask

	task automatic test_back_to_back;
		fill_random(bf16_vec_pkg::VEC_DEPTH);
		load_vectors(bf16_vec_pkg::VEC_DEPTH);
		run_vector("b2b first", bf16_vec_pkg::VEC_DEPTH);
		fill_random(7);	// second run gets its own low pairs
		load_vectors(7);
		run_vector("b2b second", 7);
		check_all("b2b");
	endtask

	initial begin
		clk     = 1'b0;
		reset   = 1'b1;
		wr_en   = 1'b0;
		wr_sel  = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		start   = 1'b0;
		len     = '0;
		rd_addr = '0;
		for (int i = 0; i < bf16_vec_pkg::VEC_DEPTH; i++) begin
			vec_a[i]     = '0;
			vec_b[i]     = '0;
			res_model[i] = '0;	// banks clear on reset
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		test_same_sign();
		test_cancellation();
		test_exponent_gap();
		test_random_vector();
		test_zero_length();
		test_busy_lockout();
		test_back_to_back();

		$display("errors: %0d word, %0d flag", word_errors, flag_errors);
		if (word_errors + flag_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: bf16_vec_add_top.sv
`timescale 1ns/1ps

module bf16_vec_add_top (
	input  logic                              clk,
	input  logic                              reset,
	// host write port
	input  logic                              wr_en,
	input  logic                              wr_sel,
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   wr_addr,
	input  bf16_vec_pkg::bf16_t               wr_data,
	// run control
	input  logic                              start,
	input  logic [bf16_vec_pkg::LEN_W-1:0]    len,
	// host read port
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   rd_addr,
	output bf16_vec_pkg::bf16_t               rd_data,
	output logic                              busy,
	output logic                              done
);

	logic                            issue_en, clear;
	logic                            issue_last, drain_empty;
	logic [bf16_vec_pkg::ADDR_W-1:0] issue_idx, wb_idx;
	logic                            wb_en;
	bf16_vec_pkg::bf16_t             op_a, op_b, sum;

	vec_add_ctrl u_ctrl (
		.clk(clk), .reset(reset),
		.start(start), .len(len),
		.issue_last(issue_last), .drain_empty(drain_empty),
		.issue_en(issue_en), .clear(clear),
		.busy(busy), .done(done)
	);

	seq_counter u_seq (
		.clk(clk), .reset(reset),
		.clear(clear), .issue_en(issue_en), .len(len),
		.issue_idx(issue_idx), .issue_last(issue_last),
		.wb_en(wb_en), .wb_idx(wb_idx), .drain_empty(drain_empty)
	);

	operand_bank u_ops (
		.clk(clk), .reset(reset),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr), .wr_data(wr_data),
		.busy(busy), .rd_idx(issue_idx),
		.op_a(op_a), .op_b(op_b)
	);

	bf16_add_pipe u_add (
		.clk(clk), .reset(reset),
		.a(op_a), .b(op_b),
		.result(sum)	// six cycles behind issue
	);

	result_bank u_res (
		.clk(clk), .reset(reset),
		.wb_en(wb_en), .wb_idx(wb_idx), .wb_data(sum),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

endmodule

// File: vec_add_ctrl.sv
`timescale 1ns/1ps

module vec_add_ctrl (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           start,
	input  logic [bf16_vec_pkg::LEN_W-1:0] len,
	input  logic                           issue_last,
	input  logic                           drain_empty,
	output logic                           issue_en,
	output logic                           clear,
	output logic                           busy,
	output logic                           done
);

	bf16_vec_pkg::ctrl_state_t state, state_nxt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= bf16_vec_pkg::IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			bf16_vec_pkg::IDLE: begin
				if (start) begin
					if (len == '0)
						state_nxt = bf16_vec_pkg::DONE;	// empty vector
					else
						state_nxt = bf16_vec_pkg::ISSUE;
				end
			end
			bf16_vec_pkg::ISSUE: begin
				if (issue_last)
					state_nxt = bf16_vec_pkg::DRAIN;
			end
			bf16_vec_pkg::DRAIN: begin
				if (drain_empty)
					state_nxt = bf16_vec_pkg::DONE;	// last sum written
			end
			default: state_nxt = bf16_vec_pkg::IDLE;	// DONE lasts one cycle
		endcase
	end

	// start is only seen in IDLE so a start while busy does nothing
	assign clear    = (state == bf16_vec_pkg::IDLE) && start;
	assign issue_en = (state == bf16_vec_pkg::ISSUE);
	assign busy     = (state == bf16_vec_pkg::ISSUE) || (state == bf16_vec_pkg::DRAIN);
	assign done     = (state == bf16_vec_pkg::DONE);	// busy already low here

endmodule

// File: seq_counter.sv
`timescale 1ns/1ps

module seq_counter (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              clear,		// start of a run
	input  logic                              issue_en,
	input  logic [bf16_vec_pkg::LEN_W-1:0]    len,
	output logic [bf16_vec_pkg::ADDR_W-1:0]   issue_idx,
	output logic                              issue_last,	// current issue is the final one
	output logic                              wb_en,
	output logic [bf16_vec_pkg::ADDR_W-1:0]   wb_idx,
	output logic                              drain_empty	// nothing in flight
);

	logic [bf16_vec_pkg::LEN_W-1:0]       len_q;	// length captured at start
	logic [bf16_vec_pkg::ADD_LATENCY-1:0] vld;		// one bit per adder stage

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			len_q     <= '0;
			issue_idx <= '0;
			wb_idx    <= '0;
			vld       <= '0;
		end else begin
			if (clear) begin
				len_q     <= len;
				issue_idx <= '0;
				wb_idx    <= '0;
			end else begin
				if (issue_en)
					issue_idx <= issue_idx + 1'b1;	// wraps after 16
				if (wb_en)
					wb_idx <= wb_idx + 1'b1;
			end
			// shadow of the adder pipeline
			vld <= {vld[bf16_vec_pkg::ADD_LATENCY-2:0], issue_en};
		end
	end

	// len_q of 0 never matches, controller skips issue then
	assign issue_last  = issue_en && ({1'b0, issue_idx} == len_q - 1'b1);
	assign wb_en       = vld[bf16_vec_pkg::ADD_LATENCY-1];	// lines up with result
	assign drain_empty = ~|vld;

endmodule

// File: result_bank.sv
`timescale 1ns/1ps

module result_bank (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              wb_en,	// sum valid this cycle
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   wb_idx,
	input  bf16_vec_pkg::bf16_t               wb_data,
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   rd_addr,
	output bf16_vec_pkg::bf16_t               rd_data	// one cycle after rd_addr
);

	bf16_vec_pkg::bf16_t mem [bf16_vec_pkg::VEC_DEPTH];

	// write-back from the adder
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			mem <= '{default: '0};
		else if (wb_en)
			mem[wb_idx] <= wb_data;
	end

	// host read port, registered
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rd_data <= '0;
		else
			rd_data <= mem[rd_addr];	// old word if same-cycle write
	end

endmodule

// File: operand_bank.sv
`timescale 1ns/1ps

module operand_bank (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              wr_en,
	input  logic                              wr_sel,	// 0 selects vector a
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   wr_addr,
	input  bf16_vec_pkg::bf16_t               wr_data,
	input  logic                              busy,		// locks out host writes
	input  logic [bf16_vec_pkg::ADDR_W-1:0]   rd_idx,
	output bf16_vec_pkg::bf16_t               op_a,
	output bf16_vec_pkg::bf16_t               op_b
);

	bf16_vec_pkg::bf16_t mem_a [bf16_vec_pkg::VEC_DEPTH];
	bf16_vec_pkg::bf16_t mem_b [bf16_vec_pkg::VEC_DEPTH];

	logic wr_ok;

	assign wr_ok = wr_en && !busy;	// writes during a run are dropped

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mem_a <= '{default: '0};
			mem_b <= '{default: '0};
		end else if (wr_ok) begin
			if (wr_sel)
				mem_b[wr_addr] <= wr_data;
			else
				mem_a[wr_addr] <= wr_data;
		end
	end

	// combinational read so the pair meets the adder in the issue cycle
	assign op_a = mem_a[rd_idx];
	assign op_b = mem_b[rd_idx];

endmodule

// File: bf16_add_pipe.sv
`timescale 1ns/1ps

module bf16_add_pipe (
	input  logic                clk,
	input  logic                reset,
	input  bf16_vec_pkg::bf16_t a,		// first operand
	input  bf16_vec_pkg::bf16_t b,		// second operand
	output bf16_vec_pkg::bf16_t result	// a + b, truncated
);

	// stage 1 regs
	logic       s1_sign_a, s1_sign_b;
	logic [7:0] s1_exp_a, s1_exp_b;
	logic [8:0] s1_mant_a, s1_mant_b;	// hidden one prepended
	logic [7:0] s1_diff_ab, s1_diff_ba;	// both exponent differences

	// stage 2 regs
	logic       s2_sign_a, s2_sign_b;
	logic [8:0] s2_mant_a, s2_mant_b;	// after alignment
	logic [7:0] s2_exp;					// larger exponent

	// stage 3 regs
	logic       s3_sub;					// signs differ
	logic       s3_sign;
	logic [8:0] s3_mant;				// bit 8 catches carry out
	logic [7:0] s3_exp;

	// stage 4 regs
	logic       s4_sign;
	logic [8:0] s4_mant;
	logic [7:0] s4_exp;

	// stage 5 regs
	logic       s5_sign;
	logic [7:0] s5_exp;
	logic [6:0] s5_mant;

	logic [2:0] s3_lz;					// normalize shift for stage 4

	// position of the leading one below bit 8, saturates at 7
	function automatic logic [2:0] leading_zeros(input logic [8:0] value);
		logic [2:0] n;
		n = 3'd7;
		for (int i = 1; i <= 7; i++) begin
			if (value[i])
				n = 3'(7 - i);	// highest set bit wins
		end
		return n;
	endfunction

	assign s3_lz = leading_zeros(s3_mant);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_sign_a  <= 1'b0;
			s1_sign_b  <= 1'b0;
			s1_exp_a   <= '0;
			s1_exp_b   <= '0;
			s1_mant_a  <= '0;
			s1_mant_b  <= '0;
			s1_diff_ab <= '0;
			s1_diff_ba <= '0;
			s2_sign_a  <= 1'b0;
			s2_sign_b  <= 1'b0;
			s2_mant_a  <= '0;
			s2_mant_b  <= '0;
			s2_exp     <= '0;
			s3_sub     <= 1'b0;
			s3_sign    <= 1'b0;
			s3_mant    <= '0;
			s3_exp     <= '0;
			s4_sign    <= 1'b0;
			s4_mant    <= '0;
			s4_exp     <= '0;
			s5_sign    <= 1'b0;
			s5_exp     <= '0;
			s5_mant    <= '0;
			result     <= '0;
		end else begin
			// stage 1 splits fields, hidden one always set even for zero
			s1_sign_a  <= a.fields.sign;
			s1_sign_b  <= b.fields.sign;
			s1_exp_a   <= a.fields.exponent;
			s1_exp_b   <= b.fields.exponent;
			s1_mant_a  <= {2'b01, a.fields.mantissa};
			s1_mant_b  <= {2'b01, b.fields.mantissa};
			s1_diff_ab <= a.fields.exponent - b.fields.exponent;
			s1_diff_ba <= b.fields.exponent - a.fields.exponent;

			// stage 2 aligns the smaller operand, shifted out bits are lost
			if (s1_exp_a > s1_exp_b) begin
				s2_mant_a <= s1_mant_a;
				s2_mant_b <= s1_mant_b >> s1_diff_ab;
				s2_exp    <= s1_exp_a;
			end else begin	// equal exponents land here too
				s2_mant_a <= s1_mant_a >> s1_diff_ba;
				s2_mant_b <= s1_mant_b;
				s2_exp    <= s1_exp_b;
			end
			s2_sign_a <= s1_sign_a;
			s2_sign_b <= s1_sign_b;

			// stage 3 adds or subtracts magnitudes
			if (s2_sign_a == s2_sign_b) begin
				s3_mant <= s2_mant_a + s2_mant_b;
				s3_sign <= s2_sign_a;
			end else if (s2_mant_a > s2_mant_b) begin
				s3_mant <= s2_mant_a - s2_mant_b;
				s3_sign <= s2_sign_a;	// larger magnitude sets the sign
			end else begin
				s3_mant <= s2_mant_b - s2_mant_a;
				s3_sign <= s2_sign_b;
			end
			s3_sub <= s2_sign_a ^ s2_sign_b;
			s3_exp <= s2_exp;

			// stage 4 renormalizes only after a subtraction
			if (s3_sub) begin
				s4_mant <= s3_mant << s3_lz;
				s4_exp  <= s3_exp - s3_lz;	// may wrap, no underflow check
			end else begin
				s4_mant <= s3_mant;
				s4_exp  <= s3_exp;
			end
			s4_sign <= s3_sign;

			// stage 5 fixes up exponent zero and carry out, then truncates
			if (s4_exp == 8'd0) begin
				s5_mant <= {1'b0, s4_mant[6:1]};	// denormal form
				s5_exp  <= s4_exp;
			end else if (s4_mant[8]) begin
				s5_mant <= s4_mant[7:1];
				s5_exp  <= s4_exp + 8'd1;
			end else begin
				s5_mant <= s4_mant[6:0];
				s5_exp  <= s4_exp;
			end
			s5_sign <= s4_sign;

			// output register
			result.raw <= {s5_sign, s5_exp, s5_mant};
		end
	end

endmodule

// File: bf16_vec_pkg.sv
package bf16_vec_pkg;

	// bank geometry
	localparam int VEC_DEPTH   = 16;	// entries per bank
	localparam int ADDR_W      = 4;		// index into a bank
	localparam int LEN_W       = 5;		// holds 0 to 16

	// cycles from operands at the adder inputs to the updated result
	localparam int ADD_LATENCY = 6;

	// bfloat16 bit fields, msb first
	typedef struct packed {
		logic       sign;
		logic [7:0] exponent;
		logic [6:0] mantissa;
	} bf16_fields_t;

	// banks and host use raw, the adder decodes fields
	typedef union packed {
		logic [15:0]  raw;
		bf16_fields_t fields;
	} bf16_t;

	// controller states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		DRAIN = 2'd2,
		DONE  = 2'd3
	} ctrl_state_t;

endpackage
